/* hdl/sv32_arch_pkg.sv */
// Sv32 architectural definitions
package sv32_arch_pkg;

    // ------------------------------------------------------------------
    // address widths
    // ------------------------------------------------------------------
    localparam int unsigned VLEN          = 32;
    localparam int unsigned PLEN          = 34;
    localparam int unsigned PPNW          = 22;
    localparam int unsigned PAGE_OFFSET_W = 12;
    localparam int unsigned VPN_W         = 20;
    // vpn0 width, the part a 4 MiB page takes from the virtual address
    localparam int unsigned MEGA_SPLIT    = 10;

    // privilege levels seen by the translation checks
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01
    } priv_lvl_t;

    // ------------------------------------------------------------------
    // page table entry, msb first as in memory
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // one exception with its cause and trap value
    typedef struct packed {
        logic [31:0] cause;
        logic [31:0] tval;
        logic        valid;
    } exc_t;

    // page fault causes from mcause
    localparam logic [31:0] INSTR_PAGE_FAULT = 32'd12;
    localparam logic [31:0] LOAD_PAGE_FAULT  = 32'd13;
    localparam logic [31:0] STORE_PAGE_FAULT = 32'd15;

endpackage

/* hdl/tlb_pkg.sv */
// TLB sizing defaults
package tlb_pkg;

    // ------------------------------------------------------------------
    // default geometry of the two first level TLBs
    // ------------------------------------------------------------------
    // entries per TLB, small and fully associative
    localparam int unsigned DEF_ITLB_ENTRIES = 2;
    localparam int unsigned DEF_DTLB_ENTRIES = 2;

    // asid width as held in satp for Sv32
    localparam int unsigned DEF_ASID_W = 9;

endpackage

/* hdl/sv32_tlb.sv */
// Fully associative Sv32 TLB
`timescale 1ns/10ps

module sv32_tlb #(
    parameter int unsigned ENTRIES    = 2,
    parameter int unsigned ASID_WIDTH = 1
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    // flush request and its qualifiers
    input  logic                                  flush_i,
    input  logic [ASID_WIDTH-1:0]                 flush_asid_i,
    input  logic [sv32_arch_pkg::VLEN-1:0]        flush_vaddr_i,
    // refill from outside
    input  logic                                  upd_valid_i,
    input  logic [sv32_arch_pkg::VPN_W-1:0]       upd_vpn_i,
    input  logic [ASID_WIDTH-1:0]                 upd_asid_i,
    input  logic                                  upd_is_4m_i,
    input  sv32_arch_pkg::pte_t                   upd_pte_i,
    // lookup
    input  logic                                  lu_access_i,
    input  logic [ASID_WIDTH-1:0]                 lu_asid_i,
    input  logic [sv32_arch_pkg::VLEN-1:0]        lu_vaddr_i,
    output logic                                  lu_hit_o,
    output sv32_arch_pkg::pte_t                   lu_pte_o,
    output logic                                  lu_is_4m_o
);

    localparam int unsigned PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int unsigned VPN_W = sv32_arch_pkg::VPN_W;
    localparam int unsigned SPLIT = sv32_arch_pkg::MEGA_SPLIT;

    // tag and content arrays
    logic [ENTRIES-1:0]      valid_q;
    logic [ENTRIES-1:0]      is_4m_q;
    logic [VPN_W-1:0]        vpn_q  [ENTRIES];
    logic [ASID_WIDTH-1:0]   asid_q [ENTRIES];
    sv32_arch_pkg::pte_t     pte_q  [ENTRIES];
    // next entry to replace
    logic [PTR_W-1:0]        rr_ptr_q;

    logic [ENTRIES-1:0]      lu_match;
    logic [ENTRIES-1:0]      flush_hit;
    logic [VPN_W-1:0]        lu_vpn;
    logic [VPN_W-1:0]        fl_vpn;

    assign lu_vpn = lu_vaddr_i[sv32_arch_pkg::VLEN-1:sv32_arch_pkg::PAGE_OFFSET_W];
    assign fl_vpn = flush_vaddr_i[sv32_arch_pkg::VLEN-1:sv32_arch_pkg::PAGE_OFFSET_W];

    // vpn1 always compared, vpn0 only for 4 KiB entries
    function automatic logic page_match(input logic [VPN_W-1:0] tag,
                                        input logic             mega,
                                        input logic [VPN_W-1:0] vpn);
        return (tag[VPN_W-1:SPLIT] == vpn[VPN_W-1:SPLIT]) &&
               (mega || (tag[SPLIT-1:0] == vpn[SPLIT-1:0]));
    endfunction

    // ------------------------------------------------------------------
    // lookup and flush matching
    // ------------------------------------------------------------------
    always_comb begin : match_logic
        logic fl_page;
        logic fl_asid;
        fl_page = 1'b0;
        fl_asid = 1'b0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            // global entries hit under any asid
            lu_match[i] = lu_access_i && valid_q[i] &&
                          page_match(vpn_q[i], is_4m_q[i], lu_vpn) &&
                          ((asid_q[i] == lu_asid_i) || pte_q[i].g);
            fl_page = page_match(vpn_q[i], is_4m_q[i], fl_vpn);
            fl_asid = (asid_q[i] == flush_asid_i);
            // four flush modes picked by which qualifiers are zero
            unique case ({flush_vaddr_i == '0, flush_asid_i == '0})
                2'b11:   flush_hit[i] = flush_i;
                2'b10:   flush_hit[i] = flush_i && fl_asid && !pte_q[i].g;
                2'b01:   flush_hit[i] = flush_i && fl_page;
                default: flush_hit[i] = flush_i && fl_page && fl_asid && !pte_q[i].g;
            endcase
        end
    end

    // content of the matching entry
    always_comb begin : lookup_mux
        lu_pte_o   = '0;
        lu_is_4m_o = 1'b0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (lu_match[i]) begin
                lu_pte_o   = pte_q[i];
                lu_is_4m_o = is_4m_q[i];
            end
        end
    end

    assign lu_hit_o = |lu_match;

    // ------------------------------------------------------------------
    // valid bits and replacement pointer
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else begin
            // flush first, a refill in the same cycle still lands
            valid_q <= valid_q & ~flush_hit;
            if (upd_valid_i) begin
                valid_q[rr_ptr_q] <= 1'b1;
                rr_ptr_q <= (rr_ptr_q == PTR_W'(ENTRIES - 1)) ? '0 : rr_ptr_q + 1'b1;
            end
        end
    end

    // tag and pte payload
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            vpn_q[rr_ptr_q]   <= upd_vpn_i;
            asid_q[rr_ptr_q]  <= upd_asid_i;
            is_4m_q[rr_ptr_q] <= upd_is_4m_i;
            pte_q[rr_ptr_q]   <= upd_pte_i;
        end
    end

    // refills never place two entries on the same page
    single_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lu_hit_o |-> $onehot0(lu_match));

endmodule

/* hdl/instr_xlate.sv */
// Fetch address translation
`timescale 1ns/10ps

module instr_xlate (
    input  logic                              enable_translation_i,
    input  sv32_arch_pkg::priv_lvl_t          priv_lvl_i,
    input  logic                              fetch_req_i,
    input  logic [sv32_arch_pkg::VLEN-1:0]    fetch_vaddr_i,
    // itlb lookup result
    input  logic                              tlb_hit_i,
    input  sv32_arch_pkg::pte_t               tlb_pte_i,
    input  logic                              tlb_is_4m_i,
    // response, same cycle as the request
    output logic                              fetch_valid_o,
    output logic [sv32_arch_pkg::PLEN-1:0]    fetch_paddr_o,
    output sv32_arch_pkg::exc_t               fetch_ex_o,
    output logic                              itlb_miss_o
);

    localparam int unsigned OFS = sv32_arch_pkg::PAGE_OFFSET_W;

    logic iaccess_err;

    // user page from S mode, or supervisor page from U mode
    assign iaccess_err = ((priv_lvl_i == sv32_arch_pkg::PRIV_U) && !tlb_pte_i.u) ||
                         ((priv_lvl_i == sv32_arch_pkg::PRIV_S) && tlb_pte_i.u);

    always_comb begin : fetch_xlate
        // bare mode, address goes straight through
        fetch_valid_o = fetch_req_i;
        fetch_paddr_o = {{(sv32_arch_pkg::PLEN - sv32_arch_pkg::VLEN){1'b0}}, fetch_vaddr_i};
        fetch_ex_o    = '0;
        if (enable_translation_i) begin
            // held back until the itlb hits
            fetch_valid_o = fetch_req_i && tlb_hit_i;
            fetch_paddr_o = {tlb_pte_i.ppn, fetch_vaddr_i[OFS-1:0]};
            // megapage keeps vpn0 of the virtual address
            if (tlb_is_4m_i) begin
                fetch_paddr_o[OFS +: sv32_arch_pkg::MEGA_SPLIT] =
                    fetch_vaddr_i[OFS +: sv32_arch_pkg::MEGA_SPLIT];
            end
            if (fetch_valid_o && iaccess_err) begin
                fetch_ex_o.cause = sv32_arch_pkg::INSTR_PAGE_FAULT;
                fetch_ex_o.tval  = fetch_vaddr_i;
                fetch_ex_o.valid = 1'b1;
            end
        end
    end

    // counted only for translated fetches
    assign itlb_miss_o = enable_translation_i && fetch_req_i && !tlb_hit_i;

    // an exception always comes with a valid fetch response
    fetch_ex_valid_a: assert final (!fetch_ex_o.valid || fetch_valid_o);

endmodule

/* hdl/data_xlate.sv */
// Load and store address translation
`timescale 1ns/10ps

module data_xlate (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              en_ld_st_translation_i,
    input  sv32_arch_pkg::priv_lvl_t          ld_st_priv_lvl_i,
    input  logic                              sum_i,
    // request from the LSU
    input  logic                              lsu_req_i,
    input  logic [sv32_arch_pkg::VLEN-1:0]    lsu_vaddr_i,
    input  logic                              lsu_is_store_i,
    input  sv32_arch_pkg::exc_t               misaligned_ex_i,
    // dtlb lookup result
    input  logic                              tlb_hit_i,
    input  sv32_arch_pkg::pte_t               tlb_pte_i,
    input  logic                              tlb_is_4m_i,
    // request cycle
    output logic                              lsu_dtlb_hit_o,
    output logic [sv32_arch_pkg::PPNW-1:0]    lsu_dtlb_ppn_o,
    // one cycle later
    output logic                              lsu_valid_o,
    output logic [sv32_arch_pkg::PLEN-1:0]    lsu_paddr_o,
    output sv32_arch_pkg::exc_t               lsu_exc_o,
    output logic                              dtlb_miss_o
);

    localparam int unsigned OFS   = sv32_arch_pkg::PAGE_OFFSET_W;
    localparam int unsigned SPLIT = sv32_arch_pkg::MEGA_SPLIT;

    logic                           req_q;
    logic                           hit_q;
    sv32_arch_pkg::exc_t            mis_ex_q;
    logic [sv32_arch_pkg::VLEN-1:0] vaddr_q;
    logic                           is_store_q;
    sv32_arch_pkg::pte_t            pte_q;
    logic                           is_4m_q;
    logic                           daccess_err;

    // ------------------------------------------------------------------
    // request cycle, early hit and ppn for the LSU
    // ------------------------------------------------------------------
    always_comb begin : early_ppn
        lsu_dtlb_hit_o = 1'b1;
        lsu_dtlb_ppn_o = {{(sv32_arch_pkg::PPNW - sv32_arch_pkg::VPN_W){1'b0}},
                          lsu_vaddr_i[sv32_arch_pkg::VLEN-1:OFS]};
        if (en_ld_st_translation_i) begin
            lsu_dtlb_hit_o = tlb_hit_i;
            lsu_dtlb_ppn_o = tlb_pte_i.ppn;
            if (tlb_is_4m_i) begin
                lsu_dtlb_ppn_o[SPLIT-1:0] = lsu_vaddr_i[OFS +: SPLIT];
            end
        end
    end

    assign dtlb_miss_o = en_ld_st_translation_i && lsu_req_i && !tlb_hit_i;

    // ------------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q    <= 1'b0;
            hit_q    <= 1'b0;
            mis_ex_q <= '0;
        end else begin
            req_q          <= lsu_req_i;
            hit_q          <= tlb_hit_i;
            mis_ex_q       <= misaligned_ex_i;
            // no request, no misaligned trap
            mis_ex_q.valid <= misaligned_ex_i.valid && lsu_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        pte_q      <= tlb_pte_i;
        is_4m_q    <= tlb_is_4m_i;
    end

    // user page from S mode without SUM, or supervisor page from U mode
    assign daccess_err = ((ld_st_priv_lvl_i == sv32_arch_pkg::PRIV_S) && !sum_i && pte_q.u) ||
                         ((ld_st_priv_lvl_i == sv32_arch_pkg::PRIV_U) && !pte_q.u);

    // ------------------------------------------------------------------
    // response cycle
    // ------------------------------------------------------------------
    always_comb begin : response
        lsu_valid_o = req_q;
        lsu_paddr_o = {{(sv32_arch_pkg::PLEN - sv32_arch_pkg::VLEN){1'b0}}, vaddr_q};
        lsu_exc_o   = mis_ex_q;
        // misaligned trap wins over any translation result
        if (en_ld_st_translation_i && !mis_ex_q.valid) begin
            lsu_valid_o = req_q && hit_q;
            lsu_paddr_o = {pte_q.ppn, vaddr_q[OFS-1:0]};
            if (is_4m_q) begin
                lsu_paddr_o[OFS +: SPLIT] = vaddr_q[OFS +: SPLIT];
            end
            if (lsu_valid_o) begin
                // stores also need write permission and a set dirty bit
                if (is_store_q && (!pte_q.w || !pte_q.d || daccess_err)) begin
                    lsu_exc_o = '{cause: sv32_arch_pkg::STORE_PAGE_FAULT,
                                  tval:  vaddr_q, valid: 1'b1};
                end else if (!is_store_q && daccess_err) begin
                    lsu_exc_o = '{cause: sv32_arch_pkg::LOAD_PAGE_FAULT,
                                  tval:  vaddr_q, valid: 1'b1};
                end
            end
        end
    end

    // a response always belongs to the request of the cycle before
    no_req_no_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !lsu_req_i |=> !lsu_valid_o);

endmodule

/* hdl/sv32_mmu.sv */
// Sv32 MMU top level
`timescale 1ns/10ps

module sv32_mmu #(
    parameter int unsigned INSTR_TLB_ENTRIES = tlb_pkg::DEF_ITLB_ENTRIES,
    parameter int unsigned DATA_TLB_ENTRIES  = tlb_pkg::DEF_DTLB_ENTRIES,
    parameter int unsigned ASID_WIDTH        = tlb_pkg::DEF_ASID_W
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // translation control from the CSRs
    input  logic                              enable_translation_i,
    input  logic                              en_ld_st_translation_i,
    input  sv32_arch_pkg::priv_lvl_t          priv_lvl_i,
    input  sv32_arch_pkg::priv_lvl_t          ld_st_priv_lvl_i,
    input  logic                              sum_i,
    input  logic [ASID_WIDTH-1:0]             asid_i,
    // sfence.vma
    input  logic                              flush_tlb_i,
    input  logic [ASID_WIDTH-1:0]             flush_asid_i,
    input  logic [sv32_arch_pkg::VLEN-1:0]    flush_vaddr_i,
    // refill, stands in for a page table walker
    input  logic                              refill_valid_i,
    input  logic                              refill_is_instr_i,
    input  logic [sv32_arch_pkg::VPN_W-1:0]   refill_vpn_i,
    input  logic [ASID_WIDTH-1:0]             refill_asid_i,
    input  logic                              refill_is_4m_i,
    input  sv32_arch_pkg::pte_t               refill_pte_i,
    // fetch side
    input  logic                              fetch_req_i,
    input  logic [sv32_arch_pkg::VLEN-1:0]    fetch_vaddr_i,
    output logic                              fetch_valid_o,
    output logic [sv32_arch_pkg::PLEN-1:0]    fetch_paddr_o,
    output sv32_arch_pkg::exc_t               fetch_ex_o,
    // load/store side
    input  logic                              lsu_req_i,
    input  logic [sv32_arch_pkg::VLEN-1:0]    lsu_vaddr_i,
    input  logic                              lsu_is_store_i,
    input  sv32_arch_pkg::exc_t               misaligned_ex_i,
    output logic                              lsu_dtlb_hit_o,
    output logic [sv32_arch_pkg::PPNW-1:0]    lsu_dtlb_ppn_o,
    output logic                              lsu_valid_o,
    output logic [sv32_arch_pkg::PLEN-1:0]    lsu_paddr_o,
    output sv32_arch_pkg::exc_t               lsu_exc_o,
    // performance counters
    output logic                              itlb_miss_o,
    output logic                              dtlb_miss_o
);

    logic                itlb_upd_valid;
    logic                dtlb_upd_valid;
    logic                itlb_hit;
    sv32_arch_pkg::pte_t itlb_pte;
    logic                itlb_is_4m;
    logic                dtlb_hit;
    sv32_arch_pkg::pte_t dtlb_pte;
    logic                dtlb_is_4m;

    // one refill port, steered to one side
    assign itlb_upd_valid = refill_valid_i && refill_is_instr_i;
    assign dtlb_upd_valid = refill_valid_i && !refill_is_instr_i;

    // ------------------------------------------------------------------
    // TLBs
    // ------------------------------------------------------------------
    sv32_tlb #(.ENTRIES(INSTR_TLB_ENTRIES), .ASID_WIDTH(ASID_WIDTH)) i_itlb (
        .clk_i, .rst_ni,
        .flush_i      (flush_tlb_i),
        .flush_asid_i, .flush_vaddr_i,
        .upd_valid_i  (itlb_upd_valid),
        .upd_vpn_i    (refill_vpn_i),
        .upd_asid_i   (refill_asid_i),
        .upd_is_4m_i  (refill_is_4m_i),
        .upd_pte_i    (refill_pte_i),
        .lu_access_i  (fetch_req_i),
        .lu_asid_i    (asid_i),
        .lu_vaddr_i   (fetch_vaddr_i),
        .lu_hit_o     (itlb_hit),
        .lu_pte_o     (itlb_pte),
        .lu_is_4m_o   (itlb_is_4m)
    );

    sv32_tlb #(.ENTRIES(DATA_TLB_ENTRIES), .ASID_WIDTH(ASID_WIDTH)) i_dtlb (
        .clk_i, .rst_ni,
        .flush_i      (flush_tlb_i),
        .flush_asid_i, .flush_vaddr_i,
        .upd_valid_i  (dtlb_upd_valid),
        .upd_vpn_i    (refill_vpn_i),
        .upd_asid_i   (refill_asid_i),
        .upd_is_4m_i  (refill_is_4m_i),
        .upd_pte_i    (refill_pte_i),
        .lu_access_i  (lsu_req_i),
        .lu_asid_i    (asid_i),
        .lu_vaddr_i   (lsu_vaddr_i),
        .lu_hit_o     (dtlb_hit),
        .lu_pte_o     (dtlb_pte),
        .lu_is_4m_o   (dtlb_is_4m)
    );

    // ------------------------------------------------------------------
    // translation paths
    // ------------------------------------------------------------------
    instr_xlate i_instr_xlate (
        .enable_translation_i, .priv_lvl_i, .fetch_req_i, .fetch_vaddr_i,
        .tlb_hit_i    (itlb_hit),
        .tlb_pte_i    (itlb_pte),
        .tlb_is_4m_i  (itlb_is_4m),
        .fetch_valid_o, .fetch_paddr_o, .fetch_ex_o, .itlb_miss_o
    );

    data_xlate i_data_xlate (
        .clk_i, .rst_ni,
        .en_ld_st_translation_i, .ld_st_priv_lvl_i, .sum_i,
        .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i, .misaligned_ex_i,
        .tlb_hit_i    (dtlb_hit),
        .tlb_pte_i    (dtlb_pte),
        .tlb_is_4m_i  (dtlb_is_4m),
        .lsu_dtlb_hit_o, .lsu_dtlb_ppn_o,
        .lsu_valid_o, .lsu_paddr_o, .lsu_exc_o, .dtlb_miss_o
    );

endmodule

/* test/tb_sv32_mmu.sv */
// Sv32 MMU testbench
`timescale 1ns/10ps

module tb_sv32_mmu;

    localparam int unsigned CLK_PERIOD   = 8;
    localparam int unsigned DRIVE_DELAY  = 1;
    localparam int unsigned ITLB_ENTRIES = 2;
    localparam int unsigned DTLB_ENTRIES = 2;
    localparam int unsigned ASID_W       = 9;
    // misaligned load and store causes from mcause
    localparam logic [31:0] MIS_LD_CAUSE = 32'd4;
    localparam logic [31:0] MIS_ST_CAUSE = 32'd6;

    logic                           clk_i;
    logic                           rst_ni;
    logic                           enable_translation_i;
    logic                           en_ld_st_translation_i;
    sv32_arch_pkg::priv_lvl_t       priv_lvl_i;
    sv32_arch_pkg::priv_lvl_t       ld_st_priv_lvl_i;
    logic                           sum_i;
    logic [ASID_W-1:0]              asid_i;
    logic                           flush_tlb_i;
    logic [ASID_W-1:0]              flush_asid_i;
    logic [31:0]                    flush_vaddr_i;
    logic                           refill_valid_i;
    logic                           refill_is_instr_i;
    logic [19:0]                    refill_vpn_i;
    logic [ASID_W-1:0]              refill_asid_i;
    logic                           refill_is_4m_i;
    sv32_arch_pkg::pte_t            refill_pte_i;
    logic                           fetch_req_i;
    logic [31:0]                    fetch_vaddr_i;
    logic                           fetch_valid_o;
    logic [33:0]                    fetch_paddr_o;
    sv32_arch_pkg::exc_t            fetch_ex_o;
    logic                           lsu_req_i;
    logic [31:0]                    lsu_vaddr_i;
    logic                           lsu_is_store_i;
    sv32_arch_pkg::exc_t            misaligned_ex_i;
    logic                           lsu_dtlb_hit_o;
    logic [21:0]                    lsu_dtlb_ppn_o;
    logic                           lsu_valid_o;
    logic [33:0]                    lsu_paddr_o;
    sv32_arch_pkg::exc_t            lsu_exc_o;
    logic                           itlb_miss_o;
    logic                           dtlb_miss_o;

    // vector lines in file order without comments
    string vec_q[$];
    bit    vec_loaded;

    sv32_mmu #(
        .INSTR_TLB_ENTRIES (ITLB_ENTRIES),
        .DATA_TLB_ENTRIES  (DTLB_ENTRIES),
        .ASID_WIDTH        (ASID_W)
    ) DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    // request and strobe inputs back to idle
    task automatic clear_inputs();
        refill_valid_i  = 1'b0;
        flush_tlb_i     = 1'b0;
        fetch_req_i     = 1'b0;
        lsu_req_i       = 1'b0;
        misaligned_ex_i = '0;
    endtask

    task automatic init_inputs();
        clear_inputs();
        enable_translation_i   = 1'b0;
        en_ld_st_translation_i = 1'b0;
        priv_lvl_i             = sv32_arch_pkg::PRIV_S;
        ld_st_priv_lvl_i       = sv32_arch_pkg::PRIV_S;
        sum_i                  = 1'b0;
        asid_i                 = '0;
        flush_asid_i           = '0;
        flush_vaddr_i          = '0;
        refill_is_instr_i      = 1'b0;
        refill_vpn_i           = '0;
        refill_asid_i          = '0;
        refill_is_4m_i         = 1'b0;
        refill_pte_i           = '0;
        fetch_vaddr_i          = '0;
        lsu_vaddr_i            = '0;
        lsu_is_store_i         = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // one task per vector operation
    // ------------------------------------------------------------------
    task automatic refill_tlb(input string line);
        string       op;
        logic [31:0] is_instr, vpn, asid, is_4m, pte;
        if ($sscanf(line, "%s %h %h %h %h %h", op, is_instr, vpn, asid, is_4m, pte) != 6)
            abort_run($sformatf("malformed refill line: %s", line));
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_inputs();
        // written on the next edge and visible from the cycle after
        refill_valid_i    = 1'b1;
        refill_is_instr_i = is_instr[0];
        refill_vpn_i      = vpn[19:0];
        refill_asid_i     = asid[ASID_W-1:0];
        refill_is_4m_i    = is_4m[0];
        refill_pte_i      = sv32_arch_pkg::pte_t'(pte);
    endtask

    task automatic flush_tlbs(input string line);
        string       op;
        logic [31:0] asid, vaddr;
        if ($sscanf(line, "%s %h %h", op, asid, vaddr) != 3)
            abort_run($sformatf("malformed flush line: %s", line));
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_inputs();
        flush_tlb_i   = 1'b1;
        flush_asid_i  = asid[ASID_W-1:0];
        flush_vaddr_i = vaddr;
    endtask

    task automatic fetch_step(input string line);
        string       op;
        logic [31:0] en, priv, asid, vaddr, e_valid, e_cause, e_exv;
        logic [35:0] e_paddr;
        if ($sscanf(line, "%s %h %h %h %h %h %h %h %h", op, en, priv, asid, vaddr,
                    e_valid, e_paddr, e_cause, e_exv) != 9)
            abort_run($sformatf("malformed fetch line: %s", line));
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_inputs();
        enable_translation_i = en[0];
        priv_lvl_i           = sv32_arch_pkg::priv_lvl_t'(priv[1:0]);
        asid_i               = asid[ASID_W-1:0];
        fetch_req_i          = 1'b1;
        fetch_vaddr_i        = vaddr;
        // combinational answer sampled mid cycle
        @(negedge clk_i);
        check_value("fetch_valid_o", fetch_valid_o, e_valid[0]);
        // a translated fetch without a valid answer is a miss
        check_value("itlb_miss_o", itlb_miss_o, en[0] && !e_valid[0]);
        check_value("fetch_ex_o.valid", fetch_ex_o.valid, e_exv[0]);
        if (e_exv[0]) begin
            check_value("fetch_ex_o.cause", fetch_ex_o.cause, e_cause);
            check_value("fetch_ex_o.tval", fetch_ex_o.tval, vaddr);
        end else if (e_valid[0]) begin
            check_value("fetch_paddr_o", fetch_paddr_o, e_paddr[33:0]);
        end
    endtask

    task automatic data_step(input string line);
        string       op;
        logic [31:0] en, priv, sum, asid, vaddr, store, mis, e_hit, e_ppn;
        logic [31:0] e_valid, e_cause, e_exv;
        logic [35:0] e_paddr;
        if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", op, en, priv, sum,
                    asid, vaddr, store, mis, e_hit, e_ppn, e_valid, e_paddr, e_cause,
                    e_exv) != 14)
            abort_run($sformatf("malformed data line: %s", line));
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_inputs();
        en_ld_st_translation_i = en[0];
        ld_st_priv_lvl_i       = sv32_arch_pkg::priv_lvl_t'(priv[1:0]);
        sum_i                  = sum[0];
        asid_i                 = asid[ASID_W-1:0];
        lsu_req_i              = 1'b1;
        lsu_vaddr_i            = vaddr;
        lsu_is_store_i         = store[0];
        if (mis[0]) begin
            misaligned_ex_i.cause = store[0] ? MIS_ST_CAUSE : MIS_LD_CAUSE;
            misaligned_ex_i.tval  = vaddr;
            misaligned_ex_i.valid = 1'b1;
        end
        // early hit and ppn in the request cycle
        @(negedge clk_i);
        check_value("lsu_dtlb_hit_o", lsu_dtlb_hit_o, e_hit[0]);
        check_value("dtlb_miss_o", dtlb_miss_o, en[0] && !e_hit[0]);
        if (e_hit[0])
            check_value("lsu_dtlb_ppn_o", lsu_dtlb_ppn_o, e_ppn[21:0]);
        // response one cycle later with the control inputs held
        @(posedge clk_i);
        #DRIVE_DELAY;
        lsu_req_i       = 1'b0;
        misaligned_ex_i = '0;
        @(negedge clk_i);
        check_value("lsu_valid_o", lsu_valid_o, e_valid[0]);
        check_value("lsu_exc_o.valid", lsu_exc_o.valid, e_exv[0]);
        if (e_exv[0]) begin
            check_value("lsu_exc_o.cause", lsu_exc_o.cause, e_cause);
            check_value("lsu_exc_o.tval", lsu_exc_o.tval, vaddr);
        end else if (e_valid[0]) begin
            check_value("lsu_paddr_o", lsu_paddr_o, e_paddr[33:0]);
        end
    endtask

    task automatic run_vector(input string line);
        string op;
        if ($sscanf(line, "%s", op) != 1)
            abort_run($sformatf("malformed vector line: %s", line));
        case (op)
            "refill": refill_tlb(line);
            "flush":  flush_tlbs(line);
            "fetch":  fetch_step(line);
            "data":   data_step(line);
            default:  abort_run($sformatf("unknown operation '%s' in vector file", op));
        endcase
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin : stimulus
        string line;
        int    fd;
        int    n;
        init_inputs();
        rst_ni = 1'b0;
        fd = $fopen("test/mmu_vectors.txt", "r");
        if (fd == 0)
            abort_run("could not open the vector file test/mmu_vectors.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip blank lines and column comments
            if (n > 0 && line.len() > 1 && line.getc(0) != "#")
                vec_q.push_back(line);
        end
        $fclose(fd);
        vec_loaded = 1'b1;
        repeat (3) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
        foreach (vec_q[i])
            run_vector(vec_q[i]);
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_inputs();
        @(posedge clk_i);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // each vector spends at most two cycles
    initial begin : watchdog
        wait (vec_loaded);
        #((vec_q.size() * 4 + 50) * CLK_PERIOD);
        abort_run("watchdog: the run timed out before all vectors were applied");
    end

endmodule

/* test/mmu_vectors.txt */
# refill is_instr vpn asid is_4m pte | flush asid vaddr | priv U=0 S=1, all hex
# fetch en priv asid vaddr valid paddr cause exv | data en priv sum asid vaddr st mis hit ppn valid paddr cause exv
fetch 1 1 000 12345678 0 000000000 0 0
fetch 0 1 000 12345678 1 012345678 0 0
data 0 1 0 000 87654321 0 0 1 087654 1 087654321 0 0
refill 1 40001 001 0 048D14CB
refill 1 80000 001 1 2AA000DB
fetch 1 1 001 40001ABC 1 012345ABC 0 0
fetch 1 0 001 40001ABC 1 012345ABC C 1
fetch 1 0 001 80312345 1 0AAB12345 0 0
fetch 1 1 001 80312345 1 0AAB12345 C 1
fetch 1 0 001 50000010 0 000000000 0 0
refill 1 50000 001 0 001DDCDB
fetch 1 0 001 50000010 1 000777010 0 0
fetch 1 1 001 40001ABC 0 000000000 0 0
fetch 1 0 003 50000010 0 000000000 0 0
refill 0 10000 002 0 000400D7
refill 0 20000 002 0 000800E3
data 1 0 0 002 10000044 0 0 1 000100 1 000100044 0 0
data 1 0 0 002 10000048 1 0 1 000100 1 000100048 0 0
data 1 1 0 002 10000044 0 0 1 000100 1 000100044 D 1
data 1 1 1 002 10000044 0 0 1 000100 1 000100044 0 0
data 1 1 0 002 20000008 1 0 1 000200 1 000200008 F 1
data 1 1 0 002 20000008 0 0 1 000200 1 000200008 0 0
data 1 0 0 002 20000008 0 0 1 000200 1 000200008 D 1
flush 002 00000000
data 1 0 0 002 10000044 0 0 0 000000 0 000000000 0 0
data 1 1 0 005 20000008 0 0 1 000200 1 000200008 0 0
refill 0 30000 002 1 15500057
data 1 0 0 002 3012F678 0 0 1 05552F 1 05552F678 0 0
data 1 0 0 002 3012F678 1 0 1 05552F 1 05552F678 F 1
flush 000 20000000
data 1 1 0 005 20000008 0 0 0 000000 0 000000000 0 0
data 1 0 0 002 3012F678 0 0 1 05552F 1 05552F678 0 0
flush 002 30000000
data 1 0 0 002 3012F678 0 0 0 000000 0 000000000 0 0
flush 000 00000000
fetch 1 0 001 80312345 0 000000000 0 0
refill 0 10000 002 0 000400D7
data 1 0 0 002 10000044 0 0 1 000100 1 000100044 0 0
data 1 0 0 002 10000045 0 1 1 000100 1 000100045 4 1
data 1 0 0 002 60000002 1 1 0 000000 1 060000002 6 1
data 0 1 0 000 00000003 0 1 1 000000 1 000000003 4 1

/* tb.f */
hdl/sv32_arch_pkg.sv
hdl/tlb_pkg.sv
hdl/sv32_tlb.sv
hdl/instr_xlate.sv
hdl/data_xlate.sv
hdl/sv32_mmu.sv
test/tb_sv32_mmu.sv

/* Bender.yml */
package:
  name: sv32_mmu

sources:
  - hdl/sv32_arch_pkg.sv
  - hdl/tlb_pkg.sv
  - hdl/sv32_tlb.sv
  - hdl/instr_xlate.sv
  - hdl/data_xlate.sv
  - hdl/sv32_mmu.sv
  - target: test
    files:
      - test/tb_sv32_mmu.sv
